/* fdc_sector.f */
+incdir+include
rtl/fdc_pkg.sv
rtl/fdc_cmd_if.sv
rtl/fdc_cmd_decode.sv
rtl/fdc_sector_exec.sv
rtl/fdc_status_result.sv
rtl/fdc_sector_top.sv
tests/tb_fdc_clock.sv
tests/tb_fdc_sector.sv

/* Bender.yml */
package:
  name: fdc_sector

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/fdc_pkg.sv
      - rtl/fdc_cmd_if.sv
      - rtl/fdc_cmd_decode.sv
      - rtl/fdc_sector_exec.sv
      - rtl/fdc_status_result.sv
      - rtl/fdc_sector_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_fdc_clock.sv
      - tests/tb_fdc_sector.sv

/* tests/tb_fdc_sector.sv */
// Random Type II command testbench with disk model, reference model and compare tasks
`timescale 1ns/1ps
`default_nettype none

`include "fdc_sector_params.svh"

module tb_fdc_sector;

	// Disk timing in clock cycles
	localparam int n_cmds   = 40;
	localparam int idx_len  = 4;
	localparam int idx_gap  = 6;
	localparam int id_len   = 8;
	localparam int data_len = 16;
	localparam int crc_len  = 4;
	localparam int gap_len  = 4;
	localparam int rev_max  = idx_len + idx_gap + 8 * (id_len + data_len + crc_len + gap_len);
	localparam int cycle_limit = n_cmds * 6 * rev_max + 20000;

	logic clk;
	logic rst_n;
	logic abort;
	logic command_start;
	fdc_pkg::fdc_byte_t command;
	logic ms_tick;
	logic index_n;
	logic ready_n;
	logic wprot_n;
	fdc_pkg::fdc_byte_t track;
	fdc_pkg::fdc_byte_t sector;
	logic idam_valid;
	fdc_pkg::fdc_byte_t idam_track;
	fdc_pkg::fdc_byte_t idam_side;
	fdc_pkg::fdc_byte_t idam_sector;
	logic dam_valid;
	logic dam_deleted;
	logic dam_crc_ok;
	logic data_rx;
	logic drq;
	logic intrq_ack;
	fdc_pkg::fdc_byte_t status;
	logic intrq;
	logic hld;
	logic enable_read_data;
	fdc_pkg::fdc_byte_t sector_out;
	logic sector_write;

	logic [15:0] lfsr = 16'd45658;
	int mismatches = 0;
	int failures = 0;
	int cycle_count = 0;
	int en_cycles = 0;
	int drq_delay = 10;
	int rev_count = 0;
	// Sector numbers the DUT should hand back in order
	fdc_pkg::fdc_byte_t exp_sectors[$];

	// Track layout picked up by the disk at the next index
	int lay_n = 4;
	fdc_pkg::fdc_byte_t lay_track = '0;
	fdc_pkg::fdc_byte_t lay_sec [8];
	logic lay_side [8];
	logic lay_del [8];
	logic lay_bad [8];

	tb_fdc_clock #(.period_ns(4.0), .reset_cycles(2)) i_tb_fdc_clock (.clk(clk), .rst_n(rst_n));

	fdc_sector_top i_fdc_sector_top (.*);

	// Maximal length taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output int v);
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | lfsr[0];
		end
	endtask

	task automatic report_failure(input string msg);
		failures++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic check_status(input fdc_pkg::fdc_byte_t got, input fdc_pkg::fdc_byte_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: status got %02h expected %02h", $time, got, exp);
		end
	endtask

	task automatic check_sector(input fdc_pkg::fdc_byte_t got, input fdc_pkg::fdc_byte_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: sector_out got %0d expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_result(input fdc_pkg::fdc_result_t got,
			input fdc_pkg::fdc_result_t exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: result got %s expected %s", $time, got.name(), exp.name());
		end
	endtask

	// Cause as the host reads it back from the status byte
	function automatic fdc_pkg::fdc_result_t result_from_status(input fdc_pkg::fdc_byte_t st);
		if (st[7])
			return fdc_pkg::not_ready;
		if (st[6])
			return fdc_pkg::write_protect;
		if (st[4])
			return fdc_pkg::record_not_found;
		if (st[3])
			return fdc_pkg::crc_error;
		return fdc_pkg::ok;
	endfunction

	// Outcome from the layout alone and the expected sector updates
	task automatic predict(input int tgt, input logic wr, input logic multi, input logic scmp,
			input logic side_bit, input logic nr, input logic wpn,
			output fdc_pkg::fdc_result_t cause, output int reads, output logic rec);
		int s;
		int p;
		int hit;
		logic fin;
		reads = 0;
		rec = 1'b0;
		cause = fdc_pkg::ok;
		s = tgt;
		fin = nr || (wr && !wpn);
		if (nr)
			cause = fdc_pkg::not_ready;
		else if (wr && !wpn)
			cause = fdc_pkg::write_protect;
		while (!fin) begin
			hit = -1;
			for (p = 0; p < lay_n; p++)
				if (lay_sec[p] == s && (!scmp || lay_side[p] == side_bit))
					hit = p;
			fin = 1'b1;
			if (hit < 0) begin
				cause = fdc_pkg::record_not_found;
			end else if (!wr) begin
				reads++;
				rec = lay_del[hit];
				if (lay_bad[hit]) begin
					cause = fdc_pkg::crc_error;
				end else if (multi) begin
					// Next sector on the same track
					s++;
					exp_sectors.push_back(fdc_pkg::fdc_byte_t'(s));
					fin = 1'b0;
				end
			end
		end
	endtask

	// Index pulse then ID field, data field, CRC bytes and gap per record
	initial begin : disk_model
		int r;
		int c;
		int play_n;
		fdc_pkg::fdc_byte_t play_track;
		fdc_pkg::fdc_byte_t play_sec [8];
		logic play_side [8];
		logic play_del [8];
		logic play_bad [8];
		@(negedge clk);
		forever begin
			play_n = lay_n;
			play_track = lay_track;
			play_sec = lay_sec;
			play_side = lay_side;
			play_del = lay_del;
			play_bad = lay_bad;
			rev_count++;
			index_n <= 1'b0;
			repeat (idx_len) @(negedge clk);
			index_n <= 1'b1;
			repeat (idx_gap) @(negedge clk);
			for (r = 0; r < play_n; r++) begin
				idam_track <= play_track;
				idam_sector <= play_sec[r];
				idam_side <= {7'b0, play_side[r]};
				dam_deleted <= play_del[r];
				// CRC result held until the next record starts
				dam_crc_ok <= !play_bad[r];
				idam_valid <= 1'b1;
				repeat (id_len) @(negedge clk);
				idam_valid <= 1'b0;
				dam_valid <= 1'b1;
				for (c = 0; c < data_len; c++) begin
					data_rx <= c[0];
					@(negedge clk);
				end
				dam_valid <= 1'b0;
				// Two strobes on odd cycles for the CRC bytes
				for (c = 0; c < crc_len; c++) begin
					data_rx <= c[0];
					@(negedge clk);
				end
				data_rx <= 1'b0;
				repeat (gap_len) @(negedge clk);
			end
		end
	end

	// Millisecond tick on every eighth cycle
	initial begin : ms_tick_gen
		forever begin
			repeat (7) @(negedge clk);
			ms_tick <= 1'b1;
			@(negedge clk);
			ms_tick <= 1'b0;
		end
	end

	// Host side DRQ raised by read data and released after a random delay
	initial begin : host_drq
		int hold;
		hold = 0;
		forever begin
			@(negedge clk);
			if (enable_read_data) begin
				drq <= 1'b1;
				hold = drq_delay;
			end else if (hold > 0) begin
				hold--;
			end else begin
				drq <= 1'b0;
			end
		end
	end

	// Read enable framing and sector register updates
	initial begin : output_monitor
		forever begin
			@(negedge clk);
			if (enable_read_data) begin
				en_cycles++;
				if (!dam_valid)
					report_failure("read enable high outside the data field");
			end
			if (sector_write) begin
				if (exp_sectors.size() == 0)
					report_failure("unexpected sector_write strobe");
				else
					check_sector(sector_out, exp_sectors.pop_front());
				sector <= sector_out;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == cycle_limit) begin
			$display("error: run did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin : stimulus
		int v;
		int k;
		int p;
		int rot;
		int tgt;
		int cycles;
		int ticks;
		int idx_falls;
		int abort_at;
		int reads;
		int r0;
		logic w_cmd;
		logic multi;
		logic settle_opt;
		logic scmp;
		logic side_bit;
		logic disk_side;
		logic nr;
		logic wpn;
		logic do_abort;
		logic got_irq;
		logic aborted;
		logic rec;
		logic idx_prev;
		fdc_pkg::fdc_result_t cause;
		fdc_pkg::fdc_byte_t exp_st;
		abort = 1'b0;
		command_start = 1'b0;
		command = '0;
		ms_tick = 1'b0;
		index_n = 1'b1;
		ready_n = 1'b0;
		wprot_n = 1'b1;
		track = '0;
		sector = '0;
		idam_valid = 1'b0;
		idam_track = '0;
		idam_side = '0;
		idam_sector = '0;
		dam_valid = 1'b0;
		dam_deleted = 1'b0;
		dam_crc_ok = 1'b0;
		data_rx = 1'b0;
		drq = 1'b0;
		intrq_ack = 1'b0;
		for (p = 0; p < 8; p++) begin
			lay_sec[p] = fdc_pkg::fdc_byte_t'(p + 1);
			lay_side[p] = 1'b0;
			lay_del[p] = 1'b0;
			lay_bad[p] = 1'b0;
		end
		@(posedge rst_n);
		@(negedge clk);
		for (k = 0; k < n_cmds; k++) begin
			// Layout of 4 to 8 consecutive sectors with a random rotation
			take_bits(3, v);
			lay_n = 4 + v % 5;
			take_bits(3, v);
			rot = v % lay_n;
			take_bits(1, v);
			disk_side = v[0];
			take_bits(8, v);
			lay_track = fdc_pkg::fdc_byte_t'(v);
			for (p = 0; p < lay_n; p++) begin
				lay_sec[p] = fdc_pkg::fdc_byte_t'((p + rot) % lay_n + 1);
				take_bits(3, v);
				lay_side[p] = disk_side ^ (v == 0);
				take_bits(2, v);
				lay_del[p] = (v == 0);
				take_bits(3, v);
				lay_bad[p] = (v == 0);
			end
			take_bits(2, v);
			w_cmd = (v == 0);
			take_bits(1, v);
			multi = v[0];
			take_bits(2, v);
			settle_opt = (v == 0);
			take_bits(1, v);
			scmp = v[0];
			take_bits(2, v);
			side_bit = disk_side ^ (v == 0);
			// One past the last sector is absent from the track
			take_bits(3, v);
			tgt = 1 + v % (lay_n + 1);
			take_bits(3, v);
			nr = (v == 0);
			take_bits(1, v);
			wpn = v[0];
			take_bits(4, v);
			drq_delay = 10 + v;
			take_bits(3, v);
			do_abort = (v == 0);
			take_bits(7, v);
			abort_at = 6 + v;
			ready_n <= nr;
			wprot_n <= wpn;
			predict(tgt, w_cmd, multi, scmp, side_bit, nr, wpn, cause, reads, rec);
			// Start once the disk has taken the new layout
			r0 = rev_count;
			while (rev_count == r0)
				@(negedge clk);
			en_cycles = 0;
			command_start <= 1'b1;
			command <= {2'b10, w_cmd, multi, side_bit, settle_opt, scmp, 1'b0};
			track <= lay_track;
			sector <= fdc_pkg::fdc_byte_t'(tgt);
			cycles = 0;
			ticks = 0;
			idx_falls = 0;
			// The command starts inside an index pulse
			idx_prev = 1'b0;
			got_irq = 1'b0;
			aborted = 1'b0;
			while (!got_irq && !aborted) begin
				@(negedge clk);
				command_start <= 1'b0;
				cycles++;
				if (ms_tick)
					ticks++;
				if (idx_prev && !index_n)
					idx_falls++;
				idx_prev = index_n;
				if (cycles == 2 && intrq)
					report_failure("intrq not cleared by the new command");
				if (intrq && cycles > 1) begin
					got_irq = 1'b1;
				end else if (do_abort && cycles == abort_at) begin
					abort <= 1'b1;
					aborted = 1'b1;
				end
			end
			if (aborted) begin
				@(negedge clk);
				abort <= 1'b0;
				// Flags and busy cleared while ready and DRQ still show
				check_status(status, {nr, 5'b0, drq, 1'b0});
				if (hld || intrq)
					report_failure("hld or intrq still set one cycle after abort");
				exp_sectors.delete();
			end else begin
				exp_st = {nr, cause == fdc_pkg::write_protect, rec && !w_cmd,
					cause == fdc_pkg::record_not_found, cause == fdc_pkg::crc_error,
					1'b0, drq, 1'b0};
				check_status(status, exp_st);
				check_result(result_from_status(status), cause);
				if (cause == fdc_pkg::not_ready && cycles != 4)
					report_failure("not ready interrupt came at the wrong edge");
				if (cause == fdc_pkg::write_protect && !settle_opt && cycles != 5)
					report_failure("write protect interrupt came at the wrong edge");
				if (cause == fdc_pkg::write_protect && settle_opt && ticks < `FDC_SETTLE_MS)
					report_failure("write protect ended before the head settle time");
				if (cause == fdc_pkg::record_not_found && !multi
						&& idx_falls != `FDC_INDEX_LIMIT + 1)
					report_failure("record not found did not come on the fifth index pulse");
				if (cause == fdc_pkg::record_not_found && multi
						&& idx_falls < `FDC_INDEX_LIMIT + 1)
					report_failure("record not found came before the fifth index pulse");
				if (en_cycles != reads * data_len)
					report_failure("read enable cycle count differs from the data fields read");
				if (cause == fdc_pkg::ok && !w_cmd && drq)
					report_failure("interrupt raised before drq was released");
				if (exp_sectors.size() != 0)
					report_failure("expected sector_write strobes did not appear");
				exp_sectors.delete();
				// Clear the interrupt from the host side now and then
				take_bits(1, v);
				if (v[0]) begin
					intrq_ack <= 1'b1;
					@(negedge clk);
					intrq_ack <= 1'b0;
					@(negedge clk);
					if (intrq)
						report_failure("intrq still set after intrq_ack");
				end
			end
			@(negedge clk);
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_fdc_clock.sv */
// Testbench clock and active low reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_fdc_clock #(
	parameter real period_ns    = 4.0,
	parameter int  reset_cycles = 2
) (
	output logic clk,
	output logic rst_n
);

	// Free running clock, low for the first half period
	initial begin
		clk = 1'b0;
		forever #(period_ns / 2.0) clk = ~clk;
	end

	// Release lands on a falling edge, clear of the sampling edge
	initial begin
		rst_n = 1'b0;
		#(period_ns * reset_cycles) rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* rtl/fdc_sector_top.sv */
// Sector path top level with decode, execute and result blocks
`timescale 1ns/1ps
`default_nettype none

module fdc_sector_top (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               abort,
	input  wire logic               command_start,
	input  wire fdc_pkg::fdc_byte_t command,
	input  wire logic               ms_tick,
	input  wire logic               index_n,
	input  wire logic               ready_n,
	input  wire logic               wprot_n,
	input  wire fdc_pkg::fdc_byte_t track,
	input  wire fdc_pkg::fdc_byte_t sector,
	input  wire logic               idam_valid,
	input  wire fdc_pkg::fdc_byte_t idam_track,
	input  wire fdc_pkg::fdc_byte_t idam_side,
	input  wire fdc_pkg::fdc_byte_t idam_sector,
	input  wire logic               dam_valid,
	input  wire logic               dam_deleted,
	input  wire logic               dam_crc_ok,
	input  wire logic               data_rx,
	input  wire logic               drq,
	input  wire logic               intrq_ack,
	output fdc_pkg::fdc_byte_t      status,
	output logic                    intrq,
	output logic                    hld,
	output logic                    enable_read_data,
	output fdc_pkg::fdc_byte_t      sector_out,
	output logic                    sector_write
);

	fdc_cmd_if cmd_bus ();
	fdc_res_if res_bus ();

	fdc_cmd_decode i_fdc_cmd_decode (
		.clk(clk), .rst_n(rst_n), .abort(abort),
		.command_start(command_start), .command(command),
		.busy(res_bus.busy), .cmd(cmd_bus.decode)
	);

	fdc_sector_exec i_fdc_sector_exec (
		.clk(clk), .rst_n(rst_n), .abort(abort),
		.cmd(cmd_bus.exec), .res(res_bus.exec),
		.ms_tick(ms_tick), .index_n(index_n), .ready_n(ready_n), .wprot_n(wprot_n),
		.track(track), .sector(sector),
		.idam_valid(idam_valid), .idam_track(idam_track),
		.idam_side(idam_side), .idam_sector(idam_sector),
		.dam_valid(dam_valid), .dam_deleted(dam_deleted), .dam_crc_ok(dam_crc_ok),
		.data_rx(data_rx), .drq(drq),
		.hld(hld), .enable_read_data(enable_read_data),
		.sector_out(sector_out), .sector_write(sector_write)
	);

	fdc_status_result i_fdc_status_result (
		.clk(clk), .rst_n(rst_n), .abort(abort),
		.cmd(cmd_bus.result), .res(res_bus.result),
		.ready_n(ready_n), .drq(drq), .intrq_ack(intrq_ack),
		.status(status), .intrq(intrq)
	);

endmodule

`default_nettype wire

/* rtl/fdc_status_result.sv */
// Type II status flags, status byte assembly and interrupt request
`timescale 1ns/1ps
`default_nettype none

module fdc_status_result (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          abort,
	fdc_cmd_if.result          cmd,
	fdc_res_if.result          res,
	input  wire logic          ready_n,
	input  wire logic          drq,
	input  wire logic          intrq_ack,
	output fdc_pkg::fdc_byte_t status,
	output logic               intrq
);

	logic wp_flag;
	logic rnf_flag;
	logic crc_flag;
	logic rec_bit;

	// Bit 5 is write fault on writes, never raised here
	assign rec_bit = res.write_cmd ? 1'b0 : res.record_type;

	// Lost data in bit 2 is not detected
	assign status = cmd.type_ii
		? {ready_n, wp_flag, rec_bit, rnf_flag, crc_flag, 1'b0, drq, res.busy}
		: '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wp_flag  <= 1'b0;
			rnf_flag <= 1'b0;
			crc_flag <= 1'b0;
		end else if (abort) begin
			wp_flag  <= 1'b0;
			rnf_flag <= 1'b0;
			crc_flag <= 1'b0;
		end else if (cmd.go) begin
			wp_flag  <= 1'b0;
			rnf_flag <= 1'b0;
			crc_flag <= 1'b0;
		end else if (res.done) begin
			// Cause is only meaningful with done
			wp_flag  <= (res.cause == fdc_pkg::write_protect);
			rnf_flag <= (res.cause == fdc_pkg::record_not_found);
			crc_flag <= (res.cause == fdc_pkg::crc_error);
		end
	end

	// Set one cycle after done, a new command or an ack clears it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			intrq <= 1'b0;
		else if (abort)
			intrq <= 1'b0;
		else if (res.done)
			intrq <= 1'b1;
		else if (intrq_ack || cmd.go)
			intrq <= 1'b0;
	end

endmodule

`default_nettype wire

/* rtl/fdc_sector_exec.sv */
// Sector search and transfer FSM with settle, index and CRC byte counters
`timescale 1ns/1ps
`default_nettype none

`include "fdc_sector_params.svh"

module fdc_sector_exec (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               abort,
	fdc_cmd_if.exec                 cmd,
	fdc_res_if.exec                 res,
	input  wire logic               ms_tick,
	input  wire logic               index_n,
	input  wire logic               ready_n,
	input  wire logic               wprot_n,
	input  wire fdc_pkg::fdc_byte_t track,
	input  wire fdc_pkg::fdc_byte_t sector,
	input  wire logic               idam_valid,
	input  wire fdc_pkg::fdc_byte_t idam_track,
	input  wire fdc_pkg::fdc_byte_t idam_side,
	input  wire fdc_pkg::fdc_byte_t idam_sector,
	input  wire logic               dam_valid,
	input  wire logic               dam_deleted,
	input  wire logic               dam_crc_ok,
	input  wire logic               data_rx,
	input  wire logic               drq,
	output logic                    hld,
	output logic                    enable_read_data,
	output fdc_pkg::fdc_byte_t      sector_out,
	output logic                    sector_write
);

	localparam int crc_cnt_w = $clog2(`FDC_CRC_BYTES + 1);

	fdc_pkg::fdc_exec_state_t state;
	logic [`FDC_SETTLE_W-1:0] wait_cnt;
	logic [`FDC_INDEX_W-1:0]  index_cnt;
	logic [crc_cnt_w-1:0]     crc_cnt;
	logic index_q;
	logic index_fall;
	logic id_match;
	logic index_over;

	assign index_fall = index_q && !index_n;

	// Fifth index edge since search began
	assign index_over = index_fall && (index_cnt >= `FDC_INDEX_W'(`FDC_INDEX_LIMIT));

	// ID compare, side bit only checked on request
	assign id_match = idam_valid && !dam_valid
		&& (idam_track == track) && (idam_sector == sector)
		&& (!cmd.side_cmp || (idam_side[0] == cmd.side));

	assign res.busy = (state != fdc_pkg::idle);
	assign enable_read_data = (state == fdc_pkg::read_data);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state           <= fdc_pkg::idle;
			hld             <= 1'b0;
			sector_write    <= 1'b0;
			res.done        <= 1'b0;
			res.cause       <= fdc_pkg::ok;
			res.record_type <= 1'b0;
			res.write_cmd   <= 1'b0;
			wait_cnt        <= '0;
			index_cnt       <= '0;
			crc_cnt         <= '0;
			index_q         <= 1'b1;
		end else if (abort) begin
			// Force interrupt drops the command at once
			state           <= fdc_pkg::idle;
			hld             <= 1'b0;
			sector_write    <= 1'b0;
			res.done        <= 1'b0;
			res.record_type <= 1'b0;
			index_q         <= index_n;
		end else begin
			res.done     <= 1'b0;
			sector_write <= 1'b0;
			index_q      <= index_n;
			if (index_fall)
				index_cnt <= index_cnt + 1'b1;
			case (state)
				fdc_pkg::idle: begin
					if (cmd.go) begin
						res.record_type <= 1'b0;
						res.write_cmd   <= cmd.write;
						state           <= fdc_pkg::prepare;
					end
				end
				fdc_pkg::prepare: begin
					if (ready_n) begin
						res.done  <= 1'b1;
						res.cause <= fdc_pkg::not_ready;
						state     <= fdc_pkg::idle;
					end else begin
						// Head stays loaded once a command found the drive ready
						hld      <= 1'b1;
						wait_cnt <= cmd.settle ? `FDC_SETTLE_W'(`FDC_SETTLE_MS) : '0;
						state    <= fdc_pkg::settle;
					end
				end
				fdc_pkg::settle: begin
					if (wait_cnt != '0) begin
						if (ms_tick)
							wait_cnt <= wait_cnt - 1'b1;
					end else if (cmd.write && !wprot_n) begin
						res.done  <= 1'b1;
						res.cause <= fdc_pkg::write_protect;
						state     <= fdc_pkg::idle;
					end else begin
						index_cnt <= '0;
						state     <= fdc_pkg::search;
					end
				end
				fdc_pkg::search: begin
					if (index_over) begin
						res.done  <= 1'b1;
						res.cause <= fdc_pkg::record_not_found;
						state     <= fdc_pkg::idle;
					end else if (id_match) begin
						state <= fdc_pkg::wait_dam;
					end
				end
				fdc_pkg::wait_dam: begin
					if (index_over) begin
						res.done  <= 1'b1;
						res.cause <= fdc_pkg::record_not_found;
						state     <= fdc_pkg::idle;
					end else if (dam_valid) begin
						res.record_type <= dam_deleted;
						state <= cmd.write ? fdc_pkg::write_data : fdc_pkg::read_data;
					end else if (!idam_valid) begin
						// Gap window closed without a data mark
						state <= fdc_pkg::search;
					end
				end
				fdc_pkg::read_data: begin
					if (!dam_valid) begin
						crc_cnt <= crc_cnt_w'(`FDC_CRC_BYTES);
						state   <= fdc_pkg::crc_skip;
					end
				end
				fdc_pkg::write_data: begin
					// Drive side frames the write, no CRC to check here
					if (!dam_valid)
						state <= fdc_pkg::cmd_end;
				end
				fdc_pkg::crc_skip: begin
					if (crc_cnt != '0) begin
						if (data_rx)
							crc_cnt <= crc_cnt - 1'b1;
					end else if (!dam_crc_ok) begin
						res.done  <= 1'b1;
						res.cause <= fdc_pkg::crc_error;
						state     <= fdc_pkg::idle;
					end else if (cmd.multiple) begin
						// Next sector, no settle delay on the way back to search
						sector_write <= 1'b1;
						wait_cnt     <= '0;
						state        <= fdc_pkg::settle;
					end else begin
						state <= fdc_pkg::cmd_end;
					end
				end
				fdc_pkg::cmd_end: begin
					// Hold off until the host took the last byte
					if (!drq) begin
						res.done  <= 1'b1;
						res.cause <= fdc_pkg::ok;
						state     <= fdc_pkg::idle;
					end
				end
				default: state <= fdc_pkg::idle;
			endcase
		end
	end

	// Next sector number, valid with sector_write
	always_ff @(posedge clk) begin
		if (state == fdc_pkg::crc_skip)
			sector_out <= sector + 1'b1;
	end

endmodule

`default_nettype wire

/* rtl/fdc_cmd_decode.sv */
// Type II command acceptance and field holding registers
`timescale 1ns/1ps
`default_nettype none

module fdc_cmd_decode (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              abort,
	input  wire logic              command_start,
	input  wire fdc_pkg::fdc_byte_t command,
	input  wire logic              busy,
	fdc_cmd_if.decode              cmd
);

	fdc_pkg::fdc_cmd_class_t cmd_class;
	logic accept;

	// Class from the top two bits
	// Force interrupt (0xD0 style) falls in Type IV
	always_comb begin
		case (command[7:6])
			2'b00, 2'b01: cmd_class = fdc_pkg::type_i;
			2'b10: cmd_class = fdc_pkg::type_ii;
			default: cmd_class = (command[5:4] == 2'b01) ? fdc_pkg::type_iv
				: fdc_pkg::type_iii;
		endcase
	end

	// A pending go counts as busy since execute is still idle
	assign accept = command_start && !busy && !cmd.go;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd.go      <= 1'b0;
			cmd.type_ii <= 1'b0;
		end else if (abort) begin
			// A pending start is dropped and the status view stays
			cmd.go <= 1'b0;
		end else begin
			cmd.go <= accept && (cmd_class == fdc_pkg::type_ii);
			if (accept)
				cmd.type_ii <= (cmd_class == fdc_pkg::type_ii);
		end
	end

	// Field bits held until the next accepted Type II byte
	always_ff @(posedge clk) begin
		if (accept && (cmd_class == fdc_pkg::type_ii)) begin
			cmd.write    <= command[5];
			cmd.multiple <= command[4];
			cmd.side     <= command[3];
			cmd.settle   <= command[2];
			cmd.side_cmp <= command[1];
		end
	end

endmodule

`default_nettype wire

/* rtl/fdc_cmd_if.sv */
// Decoded command bus and execute result bus
`timescale 1ns/1ps
`default_nettype none

interface fdc_cmd_if;
	// Start strobe and held Type II fields
	logic go;
	logic write;
	logic multiple;
	logic settle;
	logic side_cmp;
	logic side;
	// Last accepted command was Type II
	logic type_ii;

	modport decode (output go, write, multiple, settle, side_cmp, side, type_ii);
	modport exec (input go, write, multiple, settle, side_cmp, side);
	modport result (input go, type_ii);
endinterface

interface fdc_res_if;
	logic                   busy;
	// One cycle end-of-command pulse, cause valid alongside
	logic                   done;
	fdc_pkg::fdc_result_t   cause;
	// Deleted mark seen on the last data field
	logic                   record_type;
	logic                   write_cmd;

	modport exec (output busy, done, cause, record_type, write_cmd);
	modport result (input busy, done, cause, record_type, write_cmd);
endinterface

`default_nettype wire

/* rtl/fdc_pkg.sv */
// Byte type, command class, execute state and result cause enums
`default_nettype none

`include "fdc_sector_params.svh"

package fdc_pkg;

	// Register, ID field and status byte
	typedef logic [`FDC_BYTE_W-1:0] fdc_byte_t;

	// Command class as seen in the upper command bits
	typedef enum logic [1:0] {
		type_i   = 2'd0,
		type_ii  = 2'd1,
		type_iii = 2'd2,
		type_iv  = 2'd3
	} fdc_cmd_class_t;

	// Sector transfer FSM
	typedef enum logic [3:0] {
		idle       = 4'd0,
		prepare    = 4'd1,
		settle     = 4'd2,
		search     = 4'd3,
		wait_dam   = 4'd4,
		read_data  = 4'd5,
		write_data = 4'd6,
		crc_skip   = 4'd7,
		cmd_end    = 4'd8
	} fdc_exec_state_t;

	// Why a command ended
	typedef enum logic [2:0] {
		ok               = 3'd0,
		not_ready        = 3'd1,
		write_protect    = 3'd2,
		record_not_found = 3'd3,
		crc_error        = 3'd4
	} fdc_result_t;

endpackage

`default_nettype wire

/* include/fdc_sector_params.svh */
// Width, head-settle and index-limit macros for the sector path
`ifndef FDC_SECTOR_PARAMS_SVH
`define FDC_SECTOR_PARAMS_SVH

// Register and ID field width
`define FDC_BYTE_W 8

// Head settle time in 1 ms ticks
`define FDC_SETTLE_MS 15

// Settle counter width, must hold FDC_SETTLE_MS
`define FDC_SETTLE_W 5

// Index pulses tolerated before record not found
`define FDC_INDEX_LIMIT 4

// Index counter width, must hold FDC_INDEX_LIMIT + 1
`define FDC_INDEX_W 3

// CRC bytes that trail each data field
`define FDC_CRC_BYTES 2

`endif
